//--- source/ExecPkg.sv
package ExecPkg;

	localparam int dataWidth = 64;
	localparam int addrWidth = 32;
	localparam int regIdWidth = 6;
	localparam int opWidth = 8;			// Command and extension bytes
	localparam int immWidth = 33;
	localparam int shiftWidth = 8;		// Signed shift amount
	localparam int sizeWidth = 2;
	localparam int convModeWidth = 3;	// Zero-extend bit, then size
	localparam int memOpmWidth = 5;

	localparam logic [5:0] cmdNop = 6'h00;
	localparam logic [5:0] cmdInvOp = 6'h01;
	localparam logic [5:0] cmdLea = 6'h02;
	localparam logic [5:0] cmdLoad = 6'h03;
	localparam logic [5:0] cmdStore = 6'h04;
	localparam logic [5:0] cmdMovImm = 6'h05;	// LDI and LDISH forms
	localparam logic [5:0] cmdShad32 = 6'h06;
	localparam logic [5:0] cmdShld32 = 6'h07;
	localparam logic [5:0] cmdShad64 = 6'h08;
	localparam logic [5:0] cmdShld64 = 6'h09;
	localparam logic [5:0] cmdConv = 6'h0a;
	localparam logic [5:0] cmdBra = 6'h0b;
	localparam logic [5:0] cmdJmp = 6'h0c;
	localparam logic [5:0] cmdOpIxt = 6'h0d;

	localparam logic [5:0] ixtNop = 6'h00;
	localparam logic [5:0] ixtBreak = 6'h01;
	localparam logic [5:0] ixtClrT = 6'h02;
	localparam logic [5:0] ixtSetT = 6'h03;

	localparam logic [1:0] condAlways = 2'b00;
	localparam logic [1:0] condNever = 2'b01;
	localparam logic [1:0] condTrue = 2'b10;
	localparam logic [1:0] condFalse = 2'b11;

	// Access size, carried in extension bits 5:4
	localparam logic [1:0] sizeByte = 2'b00;
	localparam logic [1:0] sizeWord = 2'b01;
	localparam logic [1:0] sizeLong = 2'b10;
	localparam logic [1:0] sizeQuad = 2'b11;

	localparam logic [1:0] memOpRead = 2'b01;
	localparam logic [1:0] memOpWrite = 2'b10;
	localparam logic [memOpmWidth-1:0] memOpNone = 5'b00000;

	localparam logic [regIdWidth-1:0] regZero = 6'h00;	// Reads as zero, never written

	localparam int issueCredits = 2;
	localparam int outCredits = 4;
	localparam int queueDepth = 4;

	typedef struct packed {
		logic [regIdWidth-1:0] regId;
		logic [dataWidth-1:0] value;
	} WbEntry;

	typedef struct packed {
		logic [addrWidth-1:0] addr;
		logic [memOpmWidth-1:0] opm;	// Kind, unsigned, size
		logic [dataWidth-1:0] data;
	} MemEntry;

endpackage

//--- source/ExecAgu.sv
`timescale 1ns/10ps

module ExecAgu (
	input logic [ExecPkg::addrWidth-1:0] base,
	input logic [ExecPkg::addrWidth-1:0] index,
	input logic [ExecPkg::sizeWidth-1:0] size,
	input logic [ExecPkg::addrWidth-1:0] pc,
	input logic [ExecPkg::addrWidth-1:0] disp,
	output logic [ExecPkg::addrWidth-1:0] addr,
	output logic [ExecPkg::addrWidth-1:0] target
);

	import ExecPkg::*;

	logic [addrWidth-1:0] scaledIndex;
	logic [addrWidth-1:0] branchDisp;

	// Size code is log2 of the access bytes
	always_comb begin
		case (size)
			sizeByte: scaledIndex = index;
			sizeWord: scaledIndex = {index[addrWidth-2:0], 1'b0};
			sizeLong: scaledIndex = {index[addrWidth-3:0], 2'b00};
			default: scaledIndex = {index[addrWidth-4:0], 3'b000};
		endcase
	end

	assign branchDisp = {disp[addrWidth-2:0], 1'b0};	// Displacement counts 16-bit units

	assign addr = base + scaledIndex;
	assign target = pc + branchDisp;

endmodule

//--- source/ExecShifter.sv
`timescale 1ns/10ps

module ExecShifter (
	input logic [ExecPkg::dataWidth-1:0] value,
	input logic [ExecPkg::shiftWidth-1:0] amount,
	input logic arith,
	output logic [ExecPkg::dataWidth-1:0] value32,
	output logic [ExecPkg::dataWidth-1:0] value64
);

	import ExecPkg::*;

	logic [shiftWidth-1:0] rightAmount;
	logic signed [dataWidth-1:0] ext32;
	logic signed [dataWidth:0] ext64;
	logic signed [dataWidth-1:0] right32;
	logic signed [dataWidth:0] right64;
	logic [31:0] result32;
	logic [dataWidth-1:0] result64;

	assign rightAmount = -amount;	// Magnitude of a negative amount

	// Fill bit above the operand sets arithmetic or logical right shift
	assign ext32 = {{32{arith & value[31]}}, value[31:0]};
	assign ext64 = {arith & value[dataWidth-1], value};

	assign right32 = ext32 >>> rightAmount;
	assign right64 = ext64 >>> rightAmount;

	always_comb begin
		if (amount[shiftWidth-1]) begin
			result32 = right32[31:0];
			result64 = right64[dataWidth-1:0];
		end else begin
			result32 = value[31:0] << amount;	// Past the width gives zero
			result64 = value << amount;
		end
	end

	// SHAD sign-extends the 32-bit result, SHLD zero-extends it
	assign value32 = arith ? {{32{result32[31]}}, result32} : {32'b0, result32};
	assign value64 = result64;

endmodule

//--- source/ExecConvert.sv
`timescale 1ns/10ps

module ExecConvert (
	input logic [ExecPkg::dataWidth-1:0] value,
	input logic [ExecPkg::convModeWidth-1:0] mode,
	output logic [ExecPkg::dataWidth-1:0] result,
	output logic changed
);

	import ExecPkg::*;

	logic zeroExt;
	logic [sizeWidth-1:0] size;

	assign zeroExt = mode[convModeWidth-1];
	assign size = mode[sizeWidth-1:0];

	always_comb begin
		case (size)
			sizeByte: begin
				result = zeroExt ? {56'b0, value[7:0]} : {{56{value[7]}}, value[7:0]};
			end
			sizeWord: begin
				result = zeroExt ? {48'b0, value[15:0]} : {{48{value[15]}}, value[15:0]};
			end
			sizeLong: begin
				result = zeroExt ? {32'b0, value[31:0]} : {{32{value[31]}}, value[31:0]};
			end
			default: begin
				result = value;	// Quad is already full width
			end
		endcase
	end

	// Value did not fit the narrower type
	assign changed = result != value;

endmodule

//--- source/ExecCreditQueue.sv
`timescale 1ns/10ps

module ExecCreditQueue #(
	parameter type PayloadType = logic
) (
	input logic clock,
	input logic rst,
	input logic push,
	input PayloadType pushEntry,
	input logic credit,
	output logic full,
	output logic valid,
	output PayloadType entry
);

	import ExecPkg::*;

	localparam int ptrWidth = $clog2(queueDepth);
	localparam int countWidth = $clog2(queueDepth + 1);
	localparam int creditWidth = $clog2(outCredits + 1);

	PayloadType store [queueDepth];
	logic [ptrWidth-1:0] wrPtr;
	logic [ptrWidth-1:0] rdPtr;
	logic [countWidth-1:0] count;
	logic [creditWidth-1:0] credits;	// Receiver slots still free
	logic doPush;

	assign full = count == countWidth'(queueDepth);
	assign doPush = push && !full;

	// Send whenever something is held and the receiver has room
	assign valid = (count != '0) && (credits != '0);
	assign entry = store[rdPtr];

	always_ff @(posedge clock) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			credits <= creditWidth'(outCredits);
		end else begin
			if (doPush) wrPtr <= wrPtr + 1'b1;
			if (valid) rdPtr <= rdPtr + 1'b1;
			case ({doPush, valid})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			case ({credit, valid})	// Return and send together cancel
				2'b10: credits <= credits + 1'b1;
				2'b01: credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (doPush) store[wrPtr] <= pushEntry;
	end

endmodule

//--- source/ExecControl.sv
`timescale 1ns/10ps

module ExecControl (
	input logic clock,
	input logic rst,
	input logic opValid,
	input logic [ExecPkg::opWidth-1:0] opCmd,
	input logic [ExecPkg::opWidth-1:0] opIxt,
	input logic [ExecPkg::regIdWidth-1:0] regIdRs,
	input logic [ExecPkg::regIdWidth-1:0] regIdRt,
	input logic [ExecPkg::regIdWidth-1:0] regIdRm,
	input logic [ExecPkg::dataWidth-1:0] valRs,
	input logic [ExecPkg::dataWidth-1:0] valRt,
	input logic [ExecPkg::dataWidth-1:0] valRm,
	input logic [ExecPkg::addrWidth-1:0] valPc,
	input logic [ExecPkg::immWidth-1:0] valImm,
	input logic [ExecPkg::addrWidth-1:0] aguAddr,
	input logic [ExecPkg::addrWidth-1:0] aguTarget,
	input logic [ExecPkg::dataWidth-1:0] shiftValue32,
	input logic [ExecPkg::dataWidth-1:0] shiftValue64,
	input logic [ExecPkg::dataWidth-1:0] convValue,
	input logic convChanged,
	input logic wbFull,
	input logic memFull,
	output logic opCredit,
	output logic wbPush,
	output ExecPkg::WbEntry wbEntry,
	output logic memPush,
	output ExecPkg::MemEntry memEntry,
	output logic brValid,
	output logic [ExecPkg::addrWidth-1:0] brTarget,
	output logic srT,
	output logic halted,
	output logic [ExecPkg::sizeWidth-1:0] aguSize,
	output logic [ExecPkg::shiftWidth-1:0] shiftAmount,
	output logic shiftArith,
	output logic [ExecPkg::convModeWidth-1:0] convMode,
	output logic [ExecPkg::dataWidth-1:0] srcRs,
	output logic [ExecPkg::dataWidth-1:0] srcRt,
	output logic [ExecPkg::addrWidth-1:0] srcPc,
	output logic [ExecPkg::immWidth-1:0] srcImm
);

	import ExecPkg::*;

	typedef struct packed {
		logic [opWidth-1:0] cmd;
		logic [opWidth-1:0] ixt;
		logic [regIdWidth-1:0] rm;
		logic [dataWidth-1:0] rs;
		logic [dataWidth-1:0] rt;
		logic [dataWidth-1:0] rmVal;
		logic [addrWidth-1:0] pc;
		logic [immWidth-1:0] imm;
	} IssueEntry;

	localparam int bufPtrWidth = $clog2(issueCredits);
	localparam int bufCountWidth = $clog2(issueCredits + 1);

	IssueEntry buffer [issueCredits];
	IssueEntry incoming;
	IssueEntry head;
	logic [bufPtrWidth-1:0] wrPtr;
	logic [bufPtrWidth-1:0] rdPtr;
	logic [bufCountWidth-1:0] bufCount;
	logic headValid;
	logic opEnable;
	logic [5:0] opcode;
	logic wbReq;
	logic memReq;
	logic brReq;
	logic haltReq;
	logic nextT;
	logic [addrWidth-1:0] nextTarget;
	logic pop;

	always_comb begin
		incoming.cmd = opCmd;
		incoming.ixt = opIxt;
		incoming.rm = regIdRm;
		incoming.rs = (regIdRs == regZero) ? '0 : valRs;	// Zero register reads zero
		incoming.rt = (regIdRt == regZero) ? '0 : valRt;
		incoming.rmVal = valRm;
		incoming.pc = valPc;
		incoming.imm = valImm;
	end

	assign head = buffer[rdPtr];
	assign headValid = bufCount != '0;

	// Datapath works on the buffer head
	assign srcRs = head.rs;
	assign srcRt = head.rt;
	assign srcPc = head.pc;
	assign srcImm = head.imm;
	assign aguSize = head.ixt[5:4];
	assign shiftAmount = head.rt[shiftWidth-1:0];
	assign shiftArith = (head.cmd[5:0] == cmdShad32) || (head.cmd[5:0] == cmdShad64);
	assign convMode = {head.ixt[3], head.ixt[5:4]};

	always_comb begin
		case (head.cmd[7:6])
			condAlways: opEnable = 1'b1;
			condNever: opEnable = 1'b0;
			condTrue: opEnable = srT;
			default: opEnable = !srT;
		endcase
		opcode = opEnable ? head.cmd[5:0] : cmdNop;	// Failed condition is a no-op

		wbReq = 1'b0;
		memReq = 1'b0;
		brReq = 1'b0;
		haltReq = 1'b0;
		nextT = srT;
		nextTarget = aguTarget;
		wbEntry.regId = head.rm;
		wbEntry.value = '0;
		memEntry.addr = aguAddr;
		memEntry.opm = memOpNone;
		memEntry.data = head.rmVal;

		case (opcode)
			cmdNop: begin
			end
			cmdLea: begin
				wbReq = 1'b1;
				wbEntry.value = {32'b0, aguAddr};
			end
			cmdLoad: begin
				memReq = 1'b1;
				memEntry.opm = {memOpRead, head.ixt[3], head.ixt[5:4]};
			end
			cmdStore: begin
				memReq = 1'b1;
				memEntry.opm = {memOpWrite, head.ixt[3], head.ixt[5:4]};
			end
			cmdMovImm: begin
				wbReq = 1'b1;
				case (head.ixt[1:0])
					2'b00: wbEntry.value = {{31{head.imm[32]}}, head.imm};
					2'b01: wbEntry.value = {head.rs[55:0], head.imm[7:0]};
					2'b10: wbEntry.value = {head.rs[47:0], head.imm[15:0]};
					default: wbEntry.value = {head.rs[31:0], head.imm[31:0]};
				endcase
			end
			cmdShad32, cmdShld32: begin
				wbReq = 1'b1;
				wbEntry.value = shiftValue32;
			end
			cmdShad64, cmdShld64: begin
				wbReq = 1'b1;
				wbEntry.value = shiftValue64;
			end
			cmdConv: begin
				wbReq = 1'b1;
				wbEntry.value = convValue;
				nextT = convChanged;
			end
			cmdBra: begin
				brReq = 1'b1;
			end
			cmdJmp: begin
				brReq = 1'b1;
				nextTarget = head.rs[addrWidth-1:0];
			end
			cmdOpIxt: begin
				case (head.ixt[5:0])
					ixtNop: ;
					ixtClrT: nextT = 1'b0;
					ixtSetT: nextT = 1'b1;
					default: haltReq = 1'b1;	// BREAK or unknown extension
				endcase
			end
			default: begin
				haltReq = 1'b1;	// Covers cmdInvOp too
			end
		endcase

		wbReq = wbReq && (head.rm != regZero);
	end

	// Stall the head while its target queue is full
	assign pop = headValid && !halted && !haltReq && !(wbReq && wbFull)
		&& !(memReq && memFull);
	assign wbPush = pop && wbReq;
	assign memPush = pop && memReq;

	always_ff @(posedge clock) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			bufCount <= '0;
			opCredit <= 1'b0;
			brValid <= 1'b0;
			srT <= 1'b0;
			halted <= 1'b0;
		end else begin
			if (opValid) wrPtr <= wrPtr + 1'b1;
			if (pop) rdPtr <= rdPtr + 1'b1;
			case ({opValid, pop})
				2'b10: bufCount <= bufCount + 1'b1;
				2'b01: bufCount <= bufCount - 1'b1;
				default: bufCount <= bufCount;
			endcase
			opCredit <= pop;
			brValid <= pop && brReq;
			if (pop) srT <= nextT;
			if (headValid && haltReq) halted <= 1'b1;	// Sticky until reset
		end
	end

	always_ff @(posedge clock) begin
		if (opValid) buffer[wrPtr] <= incoming;
		if (pop && brReq) brTarget <= nextTarget;
	end

endmodule

//--- source/ExecStage.sv
`timescale 1ns/10ps

module ExecStage (
	input logic clock,
	input logic rst,
	input logic opValid,
	input logic [ExecPkg::opWidth-1:0] opCmd,
	input logic [ExecPkg::opWidth-1:0] opIxt,
	input logic [ExecPkg::regIdWidth-1:0] regIdRs,
	input logic [ExecPkg::regIdWidth-1:0] regIdRt,
	input logic [ExecPkg::regIdWidth-1:0] regIdRm,
	input logic [ExecPkg::dataWidth-1:0] valRs,
	input logic [ExecPkg::dataWidth-1:0] valRt,
	input logic [ExecPkg::dataWidth-1:0] valRm,
	input logic [ExecPkg::addrWidth-1:0] valPc,
	input logic [ExecPkg::immWidth-1:0] valImm,
	output logic opCredit,
	output logic wbValid,
	output logic [ExecPkg::regIdWidth-1:0] wbRegId,
	output logic [ExecPkg::dataWidth-1:0] wbValue,
	input logic wbCredit,
	output logic memValid,
	output logic [ExecPkg::addrWidth-1:0] memAddr,
	output logic [ExecPkg::memOpmWidth-1:0] memOpm,
	output logic [ExecPkg::dataWidth-1:0] memData,
	input logic memCredit,
	output logic brValid,
	output logic [ExecPkg::addrWidth-1:0] brTarget,
	output logic srT,
	output logic halted
);

	import ExecPkg::*;

	logic [addrWidth-1:0] aguAddr;
	logic [addrWidth-1:0] aguTarget;
	logic [sizeWidth-1:0] aguSize;
	logic [dataWidth-1:0] shiftValue32;
	logic [dataWidth-1:0] shiftValue64;
	logic [shiftWidth-1:0] shiftAmount;
	logic shiftArith;
	logic [dataWidth-1:0] convValue;
	logic convChanged;
	logic [convModeWidth-1:0] convMode;
	logic [dataWidth-1:0] srcRs;
	logic [dataWidth-1:0] srcRt;
	logic [addrWidth-1:0] srcPc;
	logic [immWidth-1:0] srcImm;
	logic wbPush;
	logic wbFull;
	WbEntry wbEntry;
	WbEntry wbHead;
	logic memPush;
	logic memFull;
	MemEntry memEntry;
	MemEntry memHead;

	ExecControl i_ExecControl (
		.clock(clock), .rst(rst),
		.opValid(opValid), .opCmd(opCmd), .opIxt(opIxt),
		.regIdRs(regIdRs), .regIdRt(regIdRt), .regIdRm(regIdRm),
		.valRs(valRs), .valRt(valRt), .valRm(valRm), .valPc(valPc), .valImm(valImm),
		.aguAddr(aguAddr), .aguTarget(aguTarget),
		.shiftValue32(shiftValue32), .shiftValue64(shiftValue64),
		.convValue(convValue), .convChanged(convChanged),
		.wbFull(wbFull), .memFull(memFull),
		.opCredit(opCredit),
		.wbPush(wbPush), .wbEntry(wbEntry),
		.memPush(memPush), .memEntry(memEntry),
		.brValid(brValid), .brTarget(brTarget),
		.srT(srT), .halted(halted),
		.aguSize(aguSize), .shiftAmount(shiftAmount), .shiftArith(shiftArith),
		.convMode(convMode),
		.srcRs(srcRs), .srcRt(srcRt), .srcPc(srcPc), .srcImm(srcImm)
	);

	ExecAgu i_ExecAgu (
		.base(srcRs[addrWidth-1:0]), .index(srcRt[addrWidth-1:0]), .size(aguSize),
		.pc(srcPc), .disp(srcImm[addrWidth-1:0]),
		.addr(aguAddr), .target(aguTarget)
	);

	ExecShifter i_ExecShifter (
		.value(srcRs), .amount(shiftAmount), .arith(shiftArith),
		.value32(shiftValue32), .value64(shiftValue64)
	);

	ExecConvert i_ExecConvert (
		.value(srcRs), .mode(convMode),
		.result(convValue), .changed(convChanged)
	);

	ExecCreditQueue #(.PayloadType(WbEntry)) wbQueue (
		.clock(clock), .rst(rst),
		.push(wbPush), .pushEntry(wbEntry), .credit(wbCredit),
		.full(wbFull), .valid(wbValid), .entry(wbHead)
	);

	ExecCreditQueue #(.PayloadType(MemEntry)) memQueue (
		.clock(clock), .rst(rst),
		.push(memPush), .pushEntry(memEntry), .credit(memCredit),
		.full(memFull), .valid(memValid), .entry(memHead)
	);

	assign wbRegId = wbHead.regId;
	assign wbValue = wbHead.value;
	assign memAddr = memHead.addr;
	assign memOpm = memHead.opm;
	assign memData = memHead.data;

endmodule

//--- verification/ExecStageTb.sv
`timescale 1ns/10ps

module ExecStageTb;

	import ExecPkg::*;

	localparam int maxVecs = 40;
	localparam int vecWords = 14;
	localparam int maxDelay = 7;	// Credit return delay mask
	localparam int fKind = 0;
	localparam int fCmd = 1;
	localparam int fIxt = 2;
	localparam int fRsId = 3;
	localparam int fRtId = 4;
	localparam int fRmId = 5;
	localparam int fRs = 6;
	localparam int fRt = 7;
	localparam int fRm = 8;
	localparam int fPc = 9;
	localparam int fImm = 10;
	localparam int fExpValue = 11;
	localparam int fExpAux = 12;
	localparam int fExpT = 13;

	logic clock;
	logic rst;
	logic opValid;
	logic [opWidth-1:0] opCmd;
	logic [opWidth-1:0] opIxt;
	logic [regIdWidth-1:0] regIdRs;
	logic [regIdWidth-1:0] regIdRt;
	logic [regIdWidth-1:0] regIdRm;
	logic [dataWidth-1:0] valRs;
	logic [dataWidth-1:0] valRt;
	logic [dataWidth-1:0] valRm;
	logic [addrWidth-1:0] valPc;
	logic [immWidth-1:0] valImm;
	logic opCredit;
	logic wbValid;
	logic [regIdWidth-1:0] wbRegId;
	logic [dataWidth-1:0] wbValue;
	logic wbCredit;
	logic memValid;
	logic [addrWidth-1:0] memAddr;
	logic [memOpmWidth-1:0] memOpm;
	logic [dataWidth-1:0] memData;
	logic memCredit;
	logic brValid;
	logic [addrWidth-1:0] brTarget;
	logic srT;
	logic halted;

	logic [63:0] stimWords [maxVecs*vecWords];
	WbEntry wbExp [$];	// Scoreboards, in issue order
	MemEntry memExp [$];
	logic [31:0] rngState;
	int nVec;
	int haltIdx;
	int nextVec;
	int popIdx;
	int issueHeld;
	int wbHeld;
	int memHeld;
	int wbOwed;
	int memOwed;
	int wbDelay;
	int memDelay;
	int cycle;
	int cycleLimit;

	ExecStage i_ExecStage (.*);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [63:0] stimField(input int v, input int f);
		return stimWords[v*vecWords+f];
	endfunction

	task automatic stopRun();
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic failWith(input string what);
		$display("Error at %0t ns: %s", $time, what);
		stopRun();
	endtask

	task automatic checkWb(input WbEntry got, input WbEntry exp);
		if (got.regId !== exp.regId) begin
			$display("** Error at %0t ns: wbRegId got %h expected %h", $time, got.regId, exp.regId);
			stopRun();
		end
		if (got.value !== exp.value) begin
			$display("** Error at %0t ns: wbValue got %h expected %h", $time, got.value, exp.value);
			stopRun();
		end
	endtask

	task automatic checkMem(input MemEntry got, input MemEntry exp);
		if (got.addr !== exp.addr) begin
			$display("** Error at %0t ns: memAddr got %h expected %h", $time, got.addr, exp.addr);
			stopRun();
		end
		if (got.opm !== exp.opm) begin
			$display("** Error at %0t ns: memOpm got %h expected %h", $time, got.opm, exp.opm);
			stopRun();
		end
		if (got.data !== exp.data) begin
			$display("** Error at %0t ns: memData got %h expected %h", $time, got.data, exp.data);
			stopRun();
		end
	endtask

	task automatic checkBranch(input logic [addrWidth-1:0] got, input logic [addrWidth-1:0] exp);
		if (got !== exp) begin
			$display("** Error at %0t ns: brTarget got %h expected %h", $time, got, exp);
			stopRun();
		end
	endtask

	task automatic checkFlag(input string name, input bit got, input bit exp);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s got %b expected %b", $time, name, got, exp);
			stopRun();
		end
	endtask

	initial begin
		$timeformat(-9, 0, "", 0);
		rst = 1'b1;
		opValid = 1'b0;
		opCmd = '0;
		opIxt = '0;
		regIdRs = '0;
		regIdRt = '0;
		regIdRm = '0;
		valRs = '0;
		valRt = '0;
		valRm = '0;
		valPc = '0;
		valImm = '0;
		wbCredit = 1'b0;
		memCredit = 1'b0;
		rngState = 32'h7fd5_714f;
		nextVec = 0;
		popIdx = 0;
		issueHeld = issueCredits;
		wbHeld = outCredits;
		memHeld = outCredits;
		wbOwed = 0;
		memOwed = 0;
		wbDelay = 0;
		memDelay = 0;
		cycle = 0;
		$readmemh("verification/execStim.txt", stimWords);
		nVec = 0;
		while (nVec < maxVecs && stimField(nVec, fKind) != 64'hF) nVec++;
		haltIdx = nVec;
		for (int v = nVec - 1; v >= 0; v--) begin
			if (stimField(v, fKind) == 64'h4) haltIdx = v;
		end
		if (haltIdx == nVec) failWith("stimulus file holds no BREAK op");
		// Each result may wait a full credit delay on both ports
		cycleLimit = nVec * (maxDelay + 2) * 4 + 500;
		repeat (3) @(posedge clock);
		rst <= 1'b0;
		while (!(halted && wbExp.size() == 0 && memExp.size() == 0 &&
			wbHeld == outCredits && memHeld == outCredits)) begin
			@(posedge clock);
		end
		repeat (20) @(posedge clock);	// Nothing may move once halted
		checkFlag("halted", halted, 1'b1);
		if (popIdx != haltIdx) begin
			failWith("opCredit count differs from the consumed ops");
		end else begin
			$display("Simulation completed successfully");
			$finish;
		end
	end

	always @(posedge clock) begin
		WbEntry gotWb;
		MemEntry gotMem;
		MemEntry expMem;
		WbEntry expWb;
		logic [63:0] aux;
		if (!rst) begin
			cycle++;
			if (cycle > cycleLimit) failWith("timeout, the DUT stopped making progress");

			if (wbValid) begin
				if (wbHeld == 0) failWith("write-back sent without a credit");
				if (wbExp.size() == 0) failWith("write-back with no expected result");
				gotWb.regId = wbRegId;
				gotWb.value = wbValue;
				checkWb(gotWb, wbExp.pop_front());
				wbHeld--;
				wbOwed++;
			end
			if (wbCredit) wbHeld++;

			if (memValid) begin
				if (memHeld == 0) failWith("memory request sent without a credit");
				if (memExp.size() == 0) failWith("memory request with no expected result");
				gotMem.addr = memAddr;
				gotMem.opm = memOpm;
				gotMem.data = memData;
				checkMem(gotMem, memExp.pop_front());
				memHeld--;
				memOwed++;
			end
			if (memCredit) memHeld++;

			// Branch pulse and T update come with the op's credit
			if (opCredit) begin
				if (popIdx >= haltIdx) failWith("op consumed after the halt");
				aux = stimField(popIdx, fExpT);
				checkFlag("srT", srT, aux[0]);
				aux = stimField(popIdx, fExpAux);
				if (stimField(popIdx, fKind) == 64'h3) begin
					if (!brValid) failWith("branch op gave no brValid pulse");
					checkBranch(brTarget, aux[addrWidth-1:0]);
				end else if (brValid) begin
					failWith("brValid on an op that is not a branch");
				end
				popIdx++;
				issueHeld++;
			end else if (brValid) begin
				failWith("brValid without an opCredit");
			end

			wbCredit <= 1'b0;
			if (wbOwed > 0) begin
				if (wbDelay == 0) begin
					wbCredit <= 1'b1;
					wbOwed--;
					rngState = xorshift32(rngState);
					wbDelay = int'(rngState[2:0]);
				end else begin
					wbDelay--;
				end
			end
			memCredit <= 1'b0;
			if (memOwed > 0) begin
				if (memDelay == 0) begin
					memCredit <= 1'b1;
					memOwed--;
					rngState = xorshift32(rngState);
					memDelay = int'(rngState[2:0]);
				end else begin
					memDelay--;
				end
			end

			opValid <= 1'b0;
			rngState = xorshift32(rngState);
			if (issueHeld > 0 && nextVec < nVec && rngState[1:0] != 2'b00) begin
				aux = stimField(nextVec, fCmd);
				opCmd <= aux[opWidth-1:0];
				aux = stimField(nextVec, fIxt);
				opIxt <= aux[opWidth-1:0];
				aux = stimField(nextVec, fRsId);
				regIdRs <= aux[regIdWidth-1:0];
				aux = stimField(nextVec, fRtId);
				regIdRt <= aux[regIdWidth-1:0];
				aux = stimField(nextVec, fRmId);
				regIdRm <= aux[regIdWidth-1:0];
				valRs <= stimField(nextVec, fRs);
				valRt <= stimField(nextVec, fRt);
				valRm <= stimField(nextVec, fRm);
				aux = stimField(nextVec, fPc);
				valPc <= aux[addrWidth-1:0];
				aux = stimField(nextVec, fImm);
				valImm <= aux[immWidth-1:0];
				opValid <= 1'b1;
				aux = stimField(nextVec, fExpAux);
				if (stimField(nextVec, fKind) == 64'h1) begin
					expWb.regId = aux[regIdWidth-1:0];
					expWb.value = stimField(nextVec, fExpValue);
					wbExp.push_back(expWb);
				end else if (stimField(nextVec, fKind) == 64'h2) begin
					expMem.addr = aux[addrWidth-1:0];
					expMem.opm = aux[addrWidth+memOpmWidth-1:addrWidth];
					expMem.data = stimField(nextVec, fExpValue);
					memExp.push_back(expMem);
				end
				issueHeld--;
				nextVec++;
			end
		end
	end

endmodule

//--- all.f
source/ExecPkg.sv
source/ExecAgu.sv
source/ExecShifter.sv
source/ExecConvert.sv
source/ExecCreditQueue.sv
source/ExecControl.sv
source/ExecStage.sv
verification/ExecStageTb.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -j 0 --top-module ExecStageTb \
		-f all.f -o simv

run: compile
	@out=$$(obj_dir/simv); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

//--- verification/execStim.txt
// kind cmd ixt rsId rtId rmId valRs valRt valRm valPc valImm expValue expAux expT
// kind 0 none, 1 write-back (aux regId), 2 memory (aux opm:addr), 3 branch, 4 halt, F end
1 05 00 01 02 03 0 0 0 0 180000000 FFFFFFFF80000000 3 0
1 05 01 01 02 04 12345678 0 0 0 AB 12345678AB 4 0
1 05 03 01 02 05 1122334455667788 0 0 0 DEADBEEF 55667788DEADBEEF 5 0
1 02 20 01 02 06 1000 10 0 0 0 1040 6 0
1 06 00 01 02 07 40000001 1 0 0 0 FFFFFFFF80000002 7 0
1 06 00 01 02 08 80000000 FC 0 0 0 FFFFFFFFF8000000 8 0
1 07 00 01 02 09 FFFFFFFF80000000 FC 0 0 0 8000000 9 0
1 08 00 01 02 0A 8000000000000000 F8 0 0 0 FF80000000000000 A 0
1 09 00 01 02 0B FF 8 0 0 0 FF00 B 0
1 09 00 01 02 0C 8000000000000000 F0 0 0 0 800000000000 C 0
2 03 18 01 02 0D 2000 3 0 0 0 0 D00002006 0
2 04 30 01 02 0E 3000 2 CAFEF00D12345678 0 0 CAFEF00D12345678 1300003010 0
0 0D 03 01 02 00 0 0 0 0 0 0 0 1
1 85 00 01 02 0E 0 0 0 0 7F 7F E 1
0 C5 00 01 02 0F 0 0 0 0 55 0 0 1
0 0D 02 01 02 00 0 0 0 0 0 0 0 0
1 C5 00 01 02 10 0 0 0 0 66 66 10 0
0 45 00 01 02 11 0 0 0 0 77 0 0 0
1 0A 00 01 02 11 80 0 0 0 0 FFFFFFFFFFFFFF80 11 1
1 0A 18 01 02 12 1234 0 0 0 0 1234 12 0
0 84 30 01 02 0E 3000 2 55 0 0 0 0 0
3 0B 00 01 02 00 0 0 0 4000 10 0 4020 0
3 0C 00 01 02 00 80001234 0 0 0 0 0 80001234 0
0 05 00 01 02 00 0 0 0 0 5 0 0 0
2 03 00 01 02 13 100 FF 0 0 0 0 8000001FF 0
4 0D 01 01 02 00 0 0 0 0 0 0 0 0
0 05 00 01 02 14 0 0 0 0 9 0 0 0
F 0 0 0 0 0 0 0 0 0 0 0 0 0
